//--- vlog.f
logic/cpuPkg.sv
logic/cpuIfs.sv
logic/alu.sv
logic/registerFile.sv
logic/controller.sv
logic/datapath.sv
logic/memory.sv
logic/cpuTop.sv
verification/cpuChecker.sv
verification/cpuTb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpuTb -f vlog.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/VcpuTb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1

//--- verification/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
	localparam int seed = 32'hd731;
	localparam int progLen = 256;
	localparam int retireTarget = 2000;
	localparam int resetCycles = 3;
	localparam int loadCycles = cpuPkg::memWords + resetCycles + 2; // whole memory goes through the host port
	localparam longint watchdogNs = longint'(loadCycles + retireTarget * 4 + 100) * 10;

	logic clk, arstN, run, loadEn;
	logic [cpuPkg::memAddrWidth-1:0] loadAddr;
	logic [cpuPkg::dataWidth-1:0] loadData;
	logic [cpuPkg::switchWidth-1:0] switches;
	logic [cpuPkg::ledWidth-1:0] leds;
	logic retireValid, retireWe;
	logic [cpuPkg::dataWidth-1:0] retirePc, retireData;
	logic [cpuPkg::regAddrWidth-1:0] retireDst;
	logic done;
	int retired, valueErrors, timingErrors;
	logic [15:0] prog [cpuPkg::memWords]; // image for the host load

	cpuTop dut0 (.*);

	cpuChecker #(.retireTarget(retireTarget)) retireCheck (
		.clk(clk), .arstN(arstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.switches(switches), .leds(leds), .retireValid(retireValid), .retirePc(retirePc),
		.retireWe(retireWe), .retireDst(retireDst), .retireData(retireData),
		.done(done), .retired(retired), .valueErrors(valueErrors), .timingErrors(timingErrors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// random words, some loads and stores steered at the io addresses
	task automatic buildProgram();
		logic [31:0] r;
		logic [3:0] scratch;
		logic [15:0] fa;
		int i;
		i = 0;
		while (i < progLen) begin
			r = $urandom;
			if ((r[15:12] == cpuPkg::opLoad || r[15:12] == cpuPkg::opStor) && r[18:16] == 3'd0
					&& i + 3 <= progLen) begin
				scratch = r[3:0]; // the address register of the load or store
				prog[i] = {cpuPkg::opXor, scratch, 4'd0, scratch}; // clear it
				prog[i + 1] = {cpuPkg::opAddi, scratch, r[19] ? 8'hFE : 8'hFF}; // ledAddr or switchAddr
				prog[i + 2] = r[15:0];
				i += 3;
			end else begin
				prog[i] = r[15:0];
				i++;
			end
		end
		// rest of memory gets a pattern over the whole address, jal lands there often
		for (int a = progLen; a < cpuPkg::memWords; a++) begin
			fa = 16'(a);
			prog[a] = (fa * 16'h9e37) ^ {fa[7:0], fa[15:8]};
		end
	endtask

	initial begin
		logic [31:0] r;
		int hold;
		void'($urandom(seed));
		arstN = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		switches = '0;
		buildProgram();
		repeat (resetCycles) @(negedge clk);
		arstN = 1'b1;
		for (int a = 0; a < cpuPkg::memWords; a++) begin
			@(negedge clk);
			loadEn = 1'b1;
			loadAddr = 10'(a);
			loadData = prog[a];
		end
		@(negedge clk);
		loadEn = 1'b0;
		run = 1'b1; // core starts at pc 0
		while (!done) begin
			r = $urandom;
			hold = int'(r[4:0]) + 1; // next switch change in 1 to 32 cycles
			repeat (hold) @(negedge clk);
			switches = r[14:5];
		end
		$display("retired %0d, value errors %0d, timing errors %0d",
			retired, valueErrors, timingErrors);
		if (valueErrors == 0 && timingErrors == 0 && retired == retireTarget) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#watchdogNs;
		$display("watchdog expired at %0t ns, retirements stopped early at %0d of %0d",
			$time, retired, retireTarget);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- verification/cpuChecker.sv
`timescale 1ns/1ns

module cpuChecker #(
	parameter int retireTarget = 2000
) (
	input logic clk,
	input logic arstN,
	input logic loadEn,
	input logic [cpuPkg::memAddrWidth-1:0] loadAddr,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	input logic [cpuPkg::switchWidth-1:0] switches,
	input logic [cpuPkg::ledWidth-1:0] leds,
	input logic retireValid,
	input logic [cpuPkg::dataWidth-1:0] retirePc,
	input logic retireWe,
	input logic [cpuPkg::regAddrWidth-1:0] retireDst,
	input logic [cpuPkg::dataWidth-1:0] retireData,
	output logic done,
	output int retired,
	output int valueErrors,
	output int timingErrors
);
	logic [15:0] regs [16]; // architectural state of the model
	logic [15:0] mem [1024]; // copy of the block memory
	logic [15:0] pc;
	logic [9:0] ledModel;
	logic z, n, l; // flags from the last compare
	logic [9:0] swPrev1, swPrev2; // switches one and two edges back
	int sinceRetire; // edges since the last strobe
	logic lastValid;

	task automatic checkValue(input string name, input logic [15:0] want, input logic [15:0] got);
		if (got !== want) begin
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, want, got);
			valueErrors++;
		end
	endtask

	function automatic logic condMet(input logic [3:0] cc);
		case (cc)
			4'd0: return z;
			4'd1: return !z;
			4'd2: return n; // signed
			4'd3: return !n;
			4'd4: return l; // unsigned
			4'd5: return !l;
			4'd6: return 1'b1;
			default: return 1'b0; // never
		endcase
	endfunction

	task automatic retireStep();
		logic [15:0] instr, a, b, rhs, sext, res, nextPc;
		logic [3:0] rd, rs;
		cpuPkg::opcode op;
		logic wantWe;
		int gap;
		// fetch from switchAddr sees the switches of the fetch edge
		instr = (pc == cpuPkg::switchAddr) ? {6'b0, swPrev2} : mem[pc[9:0]];
		op = cpuPkg::opcode'(instr[15:12]);
		rd = instr[11:8];
		rs = instr[3:0];
		sext = {{8{instr[7]}}, instr[7:0]};
		a = regs[rd];
		b = regs[rs];
		rhs = (op == cpuPkg::opCmpi) ? sext : b;
		nextPc = pc + 16'd1;
		res = '0;
		wantWe = 1'b1;
		gap = (op == cpuPkg::opLoad) ? 4 : 3;
		checkValue("retirePc", pc, retirePc);
		case (op)
			cpuPkg::opAdd: res = a + b;
			cpuPkg::opSub: res = a - b;
			cpuPkg::opAnd: res = a & b;
			cpuPkg::opOr: res = a | b;
			cpuPkg::opXor: res = a ^ b;
			cpuPkg::opMov: res = b;
			cpuPkg::opAddi: res = a + sext;
			cpuPkg::opLui: res = {instr[7:0], 8'h00};
			cpuPkg::opLoad: res = (b == cpuPkg::switchAddr) ? {6'b0, swPrev1} : mem[b[9:0]];
			cpuPkg::opJal: begin
				res = pc + 16'd1; // link
				nextPc = b; // old rSrc value even when rSrc is rDst
			end
			cpuPkg::opCmp, cpuPkg::opCmpi: begin
				wantWe = 1'b0;
				z = (a == rhs);
				n = ($signed(a) < $signed(rhs));
				l = (a < rhs);
			end
			cpuPkg::opStor: begin
				wantWe = 1'b0;
				if (b == cpuPkg::ledAddr) ledModel = a[9:0];
				else if (b != cpuPkg::switchAddr) mem[b[9:0]] = a; // io words never reach the ram
			end
			cpuPkg::opBcond: begin
				wantWe = 1'b0;
				if (condMet(rd)) nextPc = pc + 16'd1 + sext;
			end
			default: wantWe = 1'b0; // nop
		endcase
		checkValue("retireWe", {15'b0, wantWe}, {15'b0, retireWe});
		if (wantWe) begin
			checkValue("retireDst", {12'b0, rd}, {12'b0, retireDst});
			checkValue("retireData", res, retireData);
			regs[rd] = res;
		end
		if (retired > 0 && sinceRetire != gap) begin
			$display("retire at %0t ns came %0d cycles after the previous one instead of %0d",
				$time, sinceRetire, gap);
			timingErrors++;
		end
		sinceRetire = 0;
		pc = nextPc;
		retired++;
	endtask

	// model stops with the last counted retirement, the core keeps running
	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++) regs[i] = '0;
			for (int i = 0; i < 1024; i++) mem[i] = '0;
			pc = '0;
			ledModel = '0;
			{z, n, l} = 3'b000;
			swPrev1 = '0;
			swPrev2 = '0;
			sinceRetire = 0;
			lastValid = 1'b0;
			done = 1'b0;
			retired = 0;
			valueErrors = 0;
			timingErrors = 0;
		end else if (!done) begin
			if (loadEn) mem[loadAddr] = loadData; // host port
			checkValue("leds", {6'b0, ledModel}, {6'b0, leds}); // before this edge's store lands
			sinceRetire++;
			if (retireValid && lastValid) begin
				$display("retire strobe at %0t ns lasted more than one cycle", $time);
				timingErrors++;
			end
			if (retireValid) retireStep();
			if (retired >= retireTarget) done = 1'b1;
			lastValid = retireValid;
			swPrev2 = swPrev1;
			swPrev1 = switches;
		end
	end

endmodule

//--- logic/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
	input logic clk,
	input logic arstN,
	input logic run,
	input logic loadEn,
	input logic [cpuPkg::memAddrWidth-1:0] loadAddr,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	input logic [cpuPkg::switchWidth-1:0] switches,
	output logic [cpuPkg::ledWidth-1:0] leds,
	output logic retireValid,
	output logic [cpuPkg::dataWidth-1:0] retirePc,
	output logic retireWe,
	output logic [cpuPkg::regAddrWidth-1:0] retireDst,
	output logic [cpuPkg::dataWidth-1:0] retireData
);
	ctrlIf ctrlBus ();
	memIf memBus ();

	controller fsm (.clk(clk), .arstN(arstN), .run(run), .ctrl(ctrlBus.controller));

	datapath core (
		.clk(clk), .arstN(arstN), .ctrl(ctrlBus.datapath), .mem(memBus.master),
		.retirePc(retirePc), .retireWe(retireWe), .retireDst(retireDst), .retireData(retireData)
	);

	memory ram (
		.clk(clk), .arstN(arstN), .bus(memBus.slave),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.switches(switches), .leds(leds)
	);

	assign retireValid = ctrlBus.retire; // strobe straight from the FSM

endmodule

//--- logic/memory.sv
`timescale 1ns/1ns

module memory (
	input logic clk,
	input logic arstN,
	memIf.slave bus,
	input logic loadEn,
	input logic [cpuPkg::memAddrWidth-1:0] loadAddr,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	input logic [cpuPkg::switchWidth-1:0] switches,
	output logic [cpuPkg::ledWidth-1:0] leds
);
	logic [cpuPkg::dataWidth-1:0] ram [cpuPkg::memWords];
	logic [cpuPkg::dataWidth-1:0] ramQ;
	logic [cpuPkg::switchWidth-1:0] switchQ;
	logic switchSel; // last read hit switchAddr
	logic ioHit;

	assign ioHit = (bus.addr[15:1] == cpuPkg::ledAddr[15:1]); // ledAddr or switchAddr

	always_ff @(posedge clk) begin
		if (loadEn) ram[loadAddr] <= loadData; // host port wins
		else if (bus.we && !ioHit) ram[bus.addr[cpuPkg::memAddrWidth-1:0]] <= bus.wData;
		ramQ <= ram[bus.addr[cpuPkg::memAddrWidth-1:0]];
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			leds <= '0;
			switchSel <= 1'b0;
			switchQ <= '0;
		end else begin
			switchSel <= (bus.addr == cpuPkg::switchAddr);
			switchQ <= switches;
			if (bus.we && !loadEn && bus.addr == cpuPkg::ledAddr) leds <= bus.wData[cpuPkg::ledWidth-1:0];
		end
	end

	assign bus.rData = switchSel ? {6'b0, switchQ} : ramQ;

	noHostDuringRun: assert property (@(posedge clk) disable iff (!arstN) !(loadEn && bus.we))
		else $error("host load collides with a core store");

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ns

module datapath (
	input logic clk,
	input logic arstN,
	ctrlIf.datapath ctrl,
	memIf.master mem,
	output logic [cpuPkg::dataWidth-1:0] retirePc,
	output logic retireWe,
	output logic [cpuPkg::regAddrWidth-1:0] retireDst,
	output logic [cpuPkg::dataWidth-1:0] retireData
);
	logic [cpuPkg::dataWidth-1:0] pc, pcPlus1, branchTarget, pcNext;
	logic [cpuPkg::dataWidth-1:0] immSext, immZext;
	logic [cpuPkg::dataWidth-1:0] rData1, rData2; // rDst and rSrc values
	logic [cpuPkg::dataWidth-1:0] bOperand, aluY, wbData;
	cpuPkg::instrWord ir;
	cpuPkg::psrFlags psr, aluFlags;

	assign immSext = {{8{ir.iType.imm[7]}}, ir.iType.imm};
	assign immZext = {8'h00, ir.iType.imm}; // lui operand, alu shifts it up
	assign pcPlus1 = pc + 16'd1;
	assign branchTarget = pcPlus1 + immSext;

	always_comb begin
		unique case (ctrl.pcSel)
			cpuPkg::pcSelBranch: pcNext = branchTarget;
			cpuPkg::pcSelReg: pcNext = rData2; // jal through rSrc
			default: pcNext = pcPlus1;
		endcase
		unique case (ctrl.bSel)
			cpuPkg::bSelImm: bOperand = immSext;
			cpuPkg::bSelLui: bOperand = immZext;
			default: bOperand = rData2;
		endcase
		unique case (ctrl.wbSel)
			cpuPkg::wbSelMem: wbData = mem.rData; // load data, address was issued last cycle
			cpuPkg::wbSelPc1: wbData = pcPlus1;
			default: wbData = aluY;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			ir <= '0;
			psr <= '0;
		end else begin
			if (ctrl.pcEn) pc <= pcNext;
			if (ctrl.irEn) ir <= mem.rData;
			if (ctrl.psrWe) psr <= aluFlags; // compares only
		end
	end

	registerFile regFile (
		.clk(clk), .arstN(arstN),
		.we(ctrl.rfWe), .wAddr(ir.rType.rDst), .wData(wbData),
		.rAddr1(ir.rType.rDst), .rAddr2(ir.rType.rSrc),
		.rData1(rData1), .rData2(rData2)
	);

	alu coreAlu (.op(ctrl.aluSel), .a(rData1), .b(bOperand), .y(aluY), .flags(aluFlags));

	assign mem.addr = (ctrl.addrSel == cpuPkg::addrSelReg) ? rData2 : pc; // data address in rSrc
	assign mem.wData = rData1; // store value from rDst
	assign mem.we = ctrl.memWe;

	assign ctrl.instr = ir;
	assign ctrl.flags = psr;

	// pc still holds the retiring instruction until the edge
	assign retirePc = pc;
	assign retireWe = ctrl.rfWe & ctrl.retire;
	assign retireDst = ir.rType.rDst;
	assign retireData = wbData;

	psrOnlyOnCompare: assert property (@(posedge clk) disable iff (!arstN)
		ctrl.psrWe |-> ir.rType.op inside {cpuPkg::opCmp, cpuPkg::opCmpi})
		else $error("psr written by a non-compare");

endmodule

//--- logic/controller.sv
`timescale 1ns/1ns

module controller (
	input logic clk,
	input logic arstN,
	input logic run,
	ctrlIf.controller ctrl
);
	cpuPkg::cpuState state, stateNext;
	cpuPkg::opcode op;
	logic taken; // branch condition met

	assign op = ctrl.instr.rType.op;

	// condition code sits in the rDst field
	always_comb begin
		unique case (cpuPkg::condCode'(ctrl.instr.iType.rDst))
			cpuPkg::condEq: taken = ctrl.flags.z;
			cpuPkg::condNe: taken = !ctrl.flags.z;
			cpuPkg::condLt: taken = ctrl.flags.n;
			cpuPkg::condGe: taken = !ctrl.flags.n;
			cpuPkg::condLo: taken = ctrl.flags.l;
			cpuPkg::condHs: taken = !ctrl.flags.l;
			cpuPkg::condAl: taken = 1'b1;
			default: taken = 1'b0; // never
		endcase
	end

	always_comb begin
		unique case (state)
			cpuPkg::stFetch: stateNext = run ? cpuPkg::stDecode : cpuPkg::stFetch; // park while stopped
			cpuPkg::stDecode: stateNext = cpuPkg::stExecute;
			cpuPkg::stExecute: stateNext = (op == cpuPkg::opLoad) ? cpuPkg::stWriteback : cpuPkg::stFetch;
			default: stateNext = cpuPkg::stFetch;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) state <= cpuPkg::stFetch;
		else state <= stateNext;
	end

	// operand and alu selects follow the opcode, enables below gate their use
	always_comb begin
		unique case (op)
			cpuPkg::opSub, cpuPkg::opCmp, cpuPkg::opCmpi: ctrl.aluSel = cpuPkg::aluSub;
			cpuPkg::opAnd: ctrl.aluSel = cpuPkg::aluAnd;
			cpuPkg::opOr: ctrl.aluSel = cpuPkg::aluOr;
			cpuPkg::opXor: ctrl.aluSel = cpuPkg::aluXor;
			cpuPkg::opMov: ctrl.aluSel = cpuPkg::aluPassB;
			cpuPkg::opLui: ctrl.aluSel = cpuPkg::aluLui;
			default: ctrl.aluSel = cpuPkg::aluAdd; // add, addi
		endcase
		unique case (op)
			cpuPkg::opAddi, cpuPkg::opCmpi: ctrl.bSel = cpuPkg::bSelImm;
			cpuPkg::opLui: ctrl.bSel = cpuPkg::bSelLui;
			default: ctrl.bSel = cpuPkg::bSelReg;
		endcase
	end

	always_comb begin
		ctrl.pcEn = 1'b0;
		ctrl.irEn = 1'b0;
		ctrl.rfWe = 1'b0;
		ctrl.psrWe = 1'b0;
		ctrl.memWe = 1'b0;
		ctrl.retire = 1'b0;
		ctrl.pcSel = cpuPkg::pcSelNext;
		ctrl.addrSel = cpuPkg::addrSelPc; // fetch address by default
		ctrl.wbSel = cpuPkg::wbSelAlu;
		unique case (state)
			cpuPkg::stDecode: ctrl.irEn = 1'b1; // mem output holds the fetched word now
			cpuPkg::stExecute: begin
				ctrl.pcEn = (op != cpuPkg::opLoad); // load retires in writeback
				ctrl.retire = (op != cpuPkg::opLoad);
				unique case (op)
					cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor,
					cpuPkg::opMov, cpuPkg::opAddi, cpuPkg::opLui: ctrl.rfWe = 1'b1;
					cpuPkg::opCmp, cpuPkg::opCmpi: ctrl.psrWe = 1'b1;
					cpuPkg::opLoad: ctrl.addrSel = cpuPkg::addrSelReg; // issue data address
					cpuPkg::opStor: begin
						ctrl.addrSel = cpuPkg::addrSelReg;
						ctrl.memWe = 1'b1;
					end
					cpuPkg::opBcond: ctrl.pcSel = taken ? cpuPkg::pcSelBranch : cpuPkg::pcSelNext;
					cpuPkg::opJal: begin
						ctrl.rfWe = 1'b1;
						ctrl.wbSel = cpuPkg::wbSelPc1; // link
						ctrl.pcSel = cpuPkg::pcSelReg;
					end
					default: ; // nop
				endcase
			end
			cpuPkg::stWriteback: begin
				ctrl.rfWe = 1'b1;
				ctrl.wbSel = cpuPkg::wbSelMem;
				ctrl.pcEn = 1'b1;
				ctrl.retire = 1'b1;
			end
			default: ;
		endcase
	end

	memWeInExecute: assert property (@(posedge clk) disable iff (!arstN)
		ctrl.memWe |-> state == cpuPkg::stExecute)
		else $error("memWe outside execute");
	pcEnWithRetire: assert property (@(posedge clk) disable iff (!arstN)
		ctrl.pcEn == ctrl.retire)
		else $error("pcEn and retire out of step");
	retireOneCycle: assert property (@(posedge clk) disable iff (!arstN)
		ctrl.retire |=> !ctrl.retire)
		else $error("retire held for more than one cycle");

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ns

module registerFile (
	input logic clk,
	input logic arstN,
	input logic we,
	input logic [cpuPkg::regAddrWidth-1:0] wAddr,
	input logic [cpuPkg::dataWidth-1:0] wData,
	input logic [cpuPkg::regAddrWidth-1:0] rAddr1,
	input logic [cpuPkg::regAddrWidth-1:0] rAddr2,
	output logic [cpuPkg::dataWidth-1:0] rData1,
	output logic [cpuPkg::dataWidth-1:0] rData2
);
	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < cpuPkg::regCount; i++) regs[i] <= '0; // all zero at reset
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	// no bypass, a write shows up after the edge
	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

endmodule

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
	input cpuPkg::aluOp op,
	input logic [cpuPkg::dataWidth-1:0] a,
	input logic [cpuPkg::dataWidth-1:0] b,
	output logic [cpuPkg::dataWidth-1:0] y,
	output cpuPkg::psrFlags flags
);
	logic [cpuPkg::dataWidth:0] diff; // a - b with borrow out
	logic overflow;

	assign diff = {1'b0, a} - {1'b0, b};
	assign overflow = (a[15] != b[15]) && (diff[15] != a[15]);

	always_comb begin
		unique case (op)
			cpuPkg::aluAdd: y = a + b;
			cpuPkg::aluSub: y = diff[cpuPkg::dataWidth-1:0];
			cpuPkg::aluAnd: y = a & b;
			cpuPkg::aluOr: y = a | b;
			cpuPkg::aluXor: y = a ^ b;
			cpuPkg::aluPassB: y = b; // mov
			cpuPkg::aluLui: y = {b[7:0], 8'h00};
			default: y = '0;
		endcase
	end

	// compare flags are always computed, psrWe decides whether they stick
	always_comb begin
		flags.z = (diff[cpuPkg::dataWidth-1:0] == '0);
		flags.n = diff[15] ^ overflow; // signed a < b
		flags.l = diff[cpuPkg::dataWidth]; // borrow means unsigned a < b
	end

endmodule

//--- logic/cpuIfs.sv
`timescale 1ns/1ns

// control word from the FSM, instruction and flags back
interface ctrlIf;
	logic pcEn;
	logic irEn;
	logic rfWe;
	logic psrWe;
	logic [1:0] pcSel;
	logic addrSel;
	cpuPkg::aluOp aluSel;
	logic [1:0] bSel;
	logic [1:0] wbSel;
	logic memWe;
	logic retire; // last cycle of an instruction
	cpuPkg::instrWord instr;
	cpuPkg::psrFlags flags;

	modport controller (
		output pcEn, irEn, rfWe, psrWe, pcSel, addrSel, aluSel, bSel, wbSel, memWe, retire,
		input instr, flags
	);
	modport datapath (
		input pcEn, irEn, rfWe, psrWe, pcSel, addrSel, aluSel, bSel, wbSel, memWe, retire,
		output instr, flags
	);
endinterface

// core side of the block memory
interface memIf;
	logic [cpuPkg::dataWidth-1:0] addr;
	logic [cpuPkg::dataWidth-1:0] wData;
	logic we;
	logic [cpuPkg::dataWidth-1:0] rData; // valid one cycle after addr

	modport master (output addr, wData, we, input rData);
	modport slave (input addr, wData, we, output rData);
endinterface

//--- logic/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regAddrWidth = 4;
	localparam int memWords = 1024;
	localparam int memAddrWidth = 10; // low address bits used by the block memory
	localparam int ledWidth = 10;
	localparam int switchWidth = 10;

	localparam logic [dataWidth-1:0] ledAddr = 16'hFFFE; // store target for the leds
	localparam logic [dataWidth-1:0] switchAddr = 16'hFFFF; // load source for the switches

	// mux selects on ctrlIf
	localparam logic [1:0] pcSelNext = 2'd0;
	localparam logic [1:0] pcSelBranch = 2'd1;
	localparam logic [1:0] pcSelReg = 2'd2; // jal target
	localparam logic addrSelPc = 1'b0;
	localparam logic addrSelReg = 1'b1;
	localparam logic [1:0] bSelReg = 2'd0;
	localparam logic [1:0] bSelImm = 2'd1; // sign-extended imm
	localparam logic [1:0] bSelLui = 2'd2; // zero-extended imm, alu shifts it
	localparam logic [1:0] wbSelAlu = 2'd0;
	localparam logic [1:0] wbSelMem = 2'd1;
	localparam logic [1:0] wbSelPc1 = 2'd2;

	typedef enum logic [3:0] {
		opAdd, opSub, opAnd, opOr, opXor, opMov, opCmp, opAddi,
		opLui, opLoad, opStor, opBcond, opJal, opCmpi, opNop, opNopAlt
	} opcode;

	// anything past condAl never branches
	typedef enum logic [3:0] {
		condEq, condNe, condLt, condGe, condLo, condHs, condAl
	} condCode;

	typedef struct packed {
		opcode op;
		logic [regAddrWidth-1:0] rDst; // cond code for bcond
		logic [3:0] unused;
		logic [regAddrWidth-1:0] rSrc;
	} rTypeFields;

	typedef struct packed {
		opcode op;
		logic [regAddrWidth-1:0] rDst;
		logic [7:0] imm;
	} iTypeFields;

	typedef union packed {
		rTypeFields rType;
		iTypeFields iType;
	} instrWord;

	typedef struct packed {
		logic z; // equal
		logic n; // signed less
		logic l; // unsigned less
	} psrFlags;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPassB, aluLui} aluOp;

	typedef enum logic [1:0] {stFetch, stDecode, stExecute, stWriteback} cpuState;

endpackage
